// File: all.f
+incdir+source
source/calib_pkg.sv
source/calib_regs.sv
source/skid_buffer.sv
source/calibration.sv
source/calib_frontend.sv
tb/calib_frontend_tb.sv

// File: Makefile
# Verilator build and run for the calibration front end testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := calib_frontend_tb
FILELIST  := all.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(wildcard source/*.sv source/*.svh tb/*.sv)

.PHONY: all run clean

all: run

# The binary is rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -qF '*** TEST FAILED ***' $(LOG); then \
		echo "Simulation reported failure"; \
		exit 1; \
	fi
	@grep -qF '*** TEST PASSED ***' $(LOG) || \
		(echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb/calib_frontend_tb.sv
// Calibration front end testbench
// Drives register writes and a sample stream into the DUT, predicts each
// calibrated sample with a reference model and checks the output stream

`timescale 1ns/100ps
`default_nettype none

`include "calib_config.svh"

module calib_frontend_tb;

    import calib_pkg::*;

    localparam int DATA_W = `CALIB_DATA_WIDTH;
    localparam int CH = `CALIB_CHANNELS;
    localparam longint SAMPLE_MAX = (longint'(1) << (DATA_W - 1)) - 1;
    localparam longint SAMPLE_MIN = -(longint'(1) << (DATA_W - 1));
    // Samples sent by each test in the order the tests run
    localparam int TOTAL_SAMPLES = 8 + 40 + 8 + 32 + 200 + 24;
    localparam int WATCHDOG_CYCLES = TOTAL_SAMPLES * 20 + 500;

    logic clock;
    logic reset;
    logic reg_write;
    logic [`CALIB_ADDR_WIDTH-1:0] reg_address;
    logic [DATA_W-1:0] reg_data;
    logic in_valid;
    logic in_ready;
    raw_sample_t in_sample;
    logic out_valid;
    logic out_ready;
    calibrated_sample_t out_sample;

    // Shadow of the register block, updated from the writes the bench drives
    int shadow_offset[CH];
    int shadow_shift[CH];
    bit shadow_enable;

    calibrated_sample_t expected_queue[$];
    int accept_queue[$];
    calibrated_sample_t head_sample;
    int head_cycle;
    int cycle;
    int seed;
    int ready_seed;
    int ready_draw;
    int errors;
    int test_errors;
    int passed_tests;
    int failed_tests;
    bit random_ready;
    bit check_latency;
    bit saw_stall;
    string current_test;
    raw_sample_t gain_samples[16];

    calib_frontend u_dut (
        .clock(clock),
        .reset(reset),
        .reg_write(reg_write),
        .reg_address(reg_address),
        .reg_data(reg_data),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .in_sample(in_sample),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out_sample(out_sample)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // The consumer is either always ready or ready at random
    initial begin
        out_ready = 1'b1;
        forever begin
            @(posedge clock);
            #1;
            ready_draw = $random(ready_seed);
            out_ready = random_ready ? ready_draw[0] : 1'b1;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("Timeout in test %s: the run did not finish in %0d cycles",
            current_test, WATCHDOG_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    // Add the offset and clamp, then optionally scale by a power of two and clamp
    function automatic calibrated_sample_t model_calibrate(raw_sample_t raw, int offset,
            int shift, bit enable);
        calibrated_sample_t result;
        longint value;
        bit clamped;
        clamped = 1'b0;
        value = longint'(raw.data) + longint'(offset);
        if (value > SAMPLE_MAX) begin
            value = SAMPLE_MAX;
            clamped = 1'b1;
        end else if (value < SAMPLE_MIN) begin
            value = SAMPLE_MIN;
            clamped = 1'b1;
        end
        if (enable) begin
            value = value * (longint'(1) << shift);
            if (value > SAMPLE_MAX) begin
                value = SAMPLE_MAX;
                clamped = 1'b1;
            end else if (value < SAMPLE_MIN) begin
                value = SAMPLE_MIN;
                clamped = 1'b1;
            end
        end
        result.data = DATA_W'(value);
        result.channel = raw.channel;
        result.saturated = clamped;
        return result;
    endfunction

    function automatic raw_sample_t random_sample();
        raw_sample_t sample;
        int draw;
        draw = $random(seed);
        sample.data = draw[DATA_W-1:0];
        draw = $random(seed);
        sample.channel = draw[CHANNEL_WIDTH-1:0];
        return sample;
    endfunction

    task automatic report_mismatch(string what, logic [63:0] expected_value,
            logic [63:0] actual_value);
        $display("Fail %s: %s expected %0h actual %0h", current_test, what,
            expected_value, actual_value);
        errors++;
    endtask

    // The monitor, scoreboard and reference model all sample on the rising edge
    always @(posedge clock) begin
        if (reset && out_valid && out_ready) begin
            if (expected_queue.size() == 0) begin
                $display("Error in test %s: an output sample came with none pending",
                    current_test);
                errors++;
            end else begin
                head_sample = expected_queue.pop_front();
                head_cycle = accept_queue.pop_front();
                assert (out_sample == head_sample)
                    else report_mismatch("output sample", 64'(head_sample), 64'(out_sample));
                if (check_latency) begin
                    assert (cycle - head_cycle == 3)
                        else report_mismatch("latency", 64'(3), 64'(cycle - head_cycle));
                end
            end
        end
        // A write seen on this edge is already in force for a sample accepted here
        if (reset && reg_write) begin
            if (int'(reg_address) < 2 * CH) begin
                if (reg_address[0]) begin
                    shadow_shift[int'(reg_address) / 2] = int'(reg_data[`CALIB_SHIFT_WIDTH-1:0]);
                end else begin
                    shadow_offset[int'(reg_address) / 2] = int'($signed(reg_data));
                end
            end else if (int'(reg_address) == 2 * CH) begin
                shadow_enable = reg_data[0];
            end
        end
        if (reset && in_valid && in_ready) begin
            expected_queue.push_back(model_calibrate(in_sample,
                shadow_offset[in_sample.channel], shadow_shift[in_sample.channel],
                shadow_enable));
            accept_queue.push_back(cycle);
        end
        if (reset && random_ready && !in_ready) begin
            saw_stall = 1'b1;
        end
        cycle++;
    end

    reset_quiet: assert property (@(posedge clock) !reset |=> !out_valid)
        else begin
            $display("Error in test %s: out_valid was high during reset", current_test);
            errors++;
        end

    hold_stable: assert property (@(posedge clock) disable iff (!reset)
            (out_valid && !out_ready) |=> (out_valid && $stable(out_sample)))
        else begin
            $display("Error in test %s: output changed while stalled by out_ready",
                current_test);
            errors++;
        end

    // All drivers below are called 1 ns after a rising edge and return there
    task automatic write_register(int address, int data);
        reg_write = 1'b1;
        reg_address = address[`CALIB_ADDR_WIDTH-1:0];
        reg_data = data[DATA_W-1:0];
        @(posedge clock);
        #1;
        reg_write = 1'b0;
    endtask

    // Leaves in_valid high so that back to back calls stream at full rate
    task automatic send_sample(raw_sample_t sample);
        in_valid = 1'b1;
        in_sample = sample;
        do begin
            @(posedge clock);
        end while (!in_ready);
        #1;
    endtask

    task automatic send_value(int data, int channel);
        raw_sample_t sample;
        sample.data = data[DATA_W-1:0];
        sample.channel = channel[CHANNEL_WIDTH-1:0];
        send_sample(sample);
    endtask

    task automatic drain();
        in_valid = 1'b0;
        do begin
            @(posedge clock);
            #1;
        end while (expected_queue.size() != 0);
    endtask

    task automatic start_test(string name);
        current_test = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        drain();
        if (errors == test_errors) begin
            $display("Test %s passed", current_test);
            passed_tests++;
        end else begin
            $display("Test %s failed with %0d errors", current_test, errors - test_errors);
            failed_tests++;
        end
    endtask

    initial begin
        seed = 27127;
        ready_seed = seed + 1;
        reset = 1'b0;
        reg_write = 1'b0;
        reg_address = '0;
        reg_data = '0;
        in_valid = 1'b0;
        in_sample = '0;
        random_ready = 1'b0;
        check_latency = 1'b1;
        saw_stall = 1'b0;
        errors = 0;
        passed_tests = 0;
        failed_tests = 0;
        cycle = 0;
        shadow_enable = 1'b0;
        for (int c = 0; c < CH; c++) begin
            shadow_offset[c] = 0;
            shadow_shift[c] = 0;
        end

        start_test("reset_state");
        repeat (3) @(posedge clock);
        #1;
        assert (!in_ready && !out_valid)
            else report_mismatch("in_ready and out_valid in reset", 64'(0),
                64'({in_ready, out_valid}));
        reset = 1'b1;
        @(posedge clock);
        #1;
        assert (in_ready && !out_valid)
            else report_mismatch("in_ready and out_valid after reset", 64'(2),
                64'({in_ready, out_valid}));
        // Isolated samples first, then a short burst at full rate
        for (int i = 0; i < 4; i++) begin
            send_sample(random_sample());
            drain();
        end
        for (int i = 0; i < 4; i++) begin
            send_sample(random_sample());
        end
        end_test();

        start_test("channel_offset");
        write_register(0, 100);
        write_register(2, -250);
        write_register(4, 1234);
        write_register(6, -7);
        for (int i = 0; i < 40; i++) begin
            send_sample(random_sample());
        end
        end_test();

        start_test("offset_saturation");
        write_register(0, 30000);
        write_register(2, -30000);
        write_register(4, 32767);
        write_register(6, -32768);
        send_value(30000, 0);
        send_value(32767, 0);
        send_value(-30000, 1);
        send_value(-32768, 1);
        send_value(1, 2);
        send_value(-1, 3);
        send_value(-32768, 2);
        send_value(32767, 3);
        end_test();

        start_test("shift_gain");
        for (int c = 0; c < CH; c++) begin
            write_register(2 * c, 0);
        end
        write_register(1, 1);
        write_register(3, 4);
        write_register(5, 15);
        write_register(7, 8);
        write_register(2 * CH, 1);
        for (int i = 0; i < 16; i++) begin
            gain_samples[i] = random_sample();
            // Step through the channels so that every shift amount is used
            gain_samples[i].channel = CHANNEL_WIDTH'(i % CH);
            send_sample(gain_samples[i]);
        end
        drain();
        // Same samples again with the gain switched off
        write_register(2 * CH, 0);
        for (int i = 0; i < 16; i++) begin
            send_sample(gain_samples[i]);
        end
        end_test();

        start_test("back_pressure");
        write_register(0, 500);
        write_register(6, -900);
        check_latency = 1'b0;
        random_ready = 1'b1;
        saw_stall = 1'b0;
        for (int i = 0; i < 200; i++) begin
            send_sample(random_sample());
        end
        drain();
        random_ready = 1'b0;
        @(posedge clock);
        #1;
        check_latency = 1'b1;
        assert (saw_stall)
            else begin
                $display("Error in test %s: in_ready never fell under back-pressure",
                    current_test);
                errors++;
            end
        end_test();

        start_test("midstream_write");
        fork
            begin
                for (int i = 0; i < 24; i++) begin
                    send_sample(random_sample());
                end
            end
            begin
                repeat (8) @(posedge clock);
                #1;
                write_register(0, 5000);
                write_register(2, -12000);
            end
        join
        end_test();

        $display("Tests passed: %0d, failed: %0d, errors: %0d", passed_tests,
            failed_tests, errors);
        if (failed_tests == 0 && errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: source/calib_frontend.sv
// Calibration front end top level
// Input skid buffer, calibration stage and output skid buffer in series,
// with the register block supplying the coefficients as levels

`timescale 1ns/100ps
`default_nettype none

`include "calib_config.svh"

module calib_frontend (
    input logic clock,
    input logic reset,
    input logic reg_write,
    input logic [`CALIB_ADDR_WIDTH-1:0] reg_address,
    input logic [`CALIB_DATA_WIDTH-1:0] reg_data,
    input logic in_valid,
    output logic in_ready,
    input calib_pkg::raw_sample_t in_sample,
    output logic out_valid,
    input logic out_ready,
    output calib_pkg::calibrated_sample_t out_sample
);

    import calib_pkg::*;

    // Stream between the input buffer and the calibration stage
    raw_sample_t calib_in_sample;
    logic calib_in_valid;
    logic calib_in_ready;

    // Stream between the calibration stage and the output buffer
    calibrated_sample_t calib_out_sample;
    logic calib_out_valid;
    logic calib_out_ready;

    calib_coeff_array_t coeffs;
    logic shift_enable;

    calib_regs u_regs (
        .clock(clock),
        .reset(reset),
        .reg_write(reg_write),
        .reg_address(reg_address),
        .reg_data(reg_data),
        .coeffs(coeffs),
        .shift_enable(shift_enable)
    );

    // Gives the upstream source a registered ready
    skid_buffer #(.payload_t(raw_sample_t)) u_in_buffer (
        .clock(clock),
        .reset(reset),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .in_data(in_sample),
        .out_valid(calib_in_valid),
        .out_ready(calib_in_ready),
        .out_data(calib_in_sample)
    );

    calibration u_calibration (
        .clock(clock),
        .reset(reset),
        .in_valid(calib_in_valid),
        .in_ready(calib_in_ready),
        .in_sample(calib_in_sample),
        .out_valid(calib_out_valid),
        .out_ready(calib_out_ready),
        .out_sample(calib_out_sample),
        .coeffs(coeffs),
        .shift_enable(shift_enable)
    );

    // Breaks the combinational ready path from the consumer into calibration
    skid_buffer #(.payload_t(calibrated_sample_t)) u_out_buffer (
        .clock(clock),
        .reset(reset),
        .in_valid(calib_out_valid),
        .in_ready(calib_out_ready),
        .in_data(calib_out_sample),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out_data(out_sample)
    );

endmodule

`default_nettype wire

// File: source/calibration.sv
// Calibration stage
// Adds the channel offset with saturation, then optionally applies the
// channel's power-of-two gain with a second saturation, in one register stage

`timescale 1ns/100ps
`default_nettype none

`include "calib_config.svh"

module calibration (
    input logic clock,
    input logic reset,
    input logic in_valid,
    output logic in_ready,
    input calib_pkg::raw_sample_t in_sample,
    output logic out_valid,
    input logic out_ready,
    output calib_pkg::calibrated_sample_t out_sample,
    input calib_pkg::calib_coeff_array_t coeffs,
    input logic shift_enable
);

    import calib_pkg::*;

    localparam int WIDTH = `CALIB_DATA_WIDTH;
    localparam int SHIFT_MAX = (1 << `CALIB_SHIFT_WIDTH) - 1;
    // Wide enough that the largest shift never drops a bit
    localparam int WIDE = WIDTH + SHIFT_MAX;
    localparam logic [WIDTH-1:0] MAX_VALUE = {1'b0, {(WIDTH-1){1'b1}}};
    localparam logic [WIDTH-1:0] MIN_VALUE = {1'b1, {(WIDTH-1){1'b0}}};

    calib_coeff_t coeff;
    logic [WIDTH:0] sum;
    logic [WIDTH-1:0] offset_value;
    logic offset_clamped;
    logic [WIDE-1:0] shifted;
    logic [WIDTH-1:0] gain_value;
    logic gain_clamped;
    logic advance;
    calibrated_sample_t result;

    // Coefficients are taken as they stand on the transfer edge
    assign coeff = coeffs[in_sample.channel];

    always_comb begin
        // Sign-extended sum one bit wider than a sample
        sum = {in_sample.data[WIDTH-1], in_sample.data} + {coeff.offset[WIDTH-1], coeff.offset};
        // The two top bits differ only when the sum left the signed range
        offset_clamped = sum[WIDTH] ^ sum[WIDTH-1];
        if (offset_clamped) begin
            offset_value = sum[WIDTH] ? MIN_VALUE : MAX_VALUE;
        end else begin
            offset_value = sum[WIDTH-1:0];
        end

        shifted = {{SHIFT_MAX{offset_value[WIDTH-1]}}, offset_value} << coeff.shift;
        // The top bit is still the sign, everything from the sample's sign
        // position upwards must agree with it
        gain_clamped = (shifted[WIDE-1:WIDTH-1] != '0) && (shifted[WIDE-1:WIDTH-1] != '1);
        if (gain_clamped) begin
            gain_value = shifted[WIDE-1] ? MIN_VALUE : MAX_VALUE;
        end else begin
            gain_value = shifted[WIDTH-1:0];
        end

        result.data = shift_enable ? gain_value : offset_value;
        result.channel = in_sample.channel;
        result.saturated = offset_clamped | (shift_enable & gain_clamped);
    end

    // The stage moves when its register is empty or being drained
    assign in_ready = ~out_valid | out_ready;
    assign advance = in_valid & in_ready;

    always_ff @(posedge clock) begin
        if (!reset) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (advance) begin
            out_sample <= result;
        end
    end

endmodule

`default_nettype wire

// File: source/skid_buffer.sv
// Two-entry valid/ready skid buffer
// Registers both the output stage and the upstream ready, so no
// combinational path runs from out_ready back to in_ready

`timescale 1ns/100ps
`default_nettype none

module skid_buffer #(
    parameter type payload_t = logic
) (
    input logic clock,
    input logic reset,
    input logic in_valid,
    output logic in_ready,
    input payload_t in_data,
    output logic out_valid,
    input logic out_ready,
    output payload_t out_data
);

    payload_t spare_data;
    logic spare_valid;
    logic in_fire;
    logic main_free;

    assign in_fire = in_valid & in_ready;

    // The main register can take a new beat when it is empty or is
    // being drained on this edge
    assign main_free = ~out_valid | out_ready;

    always_ff @(posedge clock) begin
        if (!reset) begin
            out_valid <= 1'b0;
            spare_valid <= 1'b0;
            in_ready <= 1'b0;
        end else if (main_free) begin
            // The spare always drains first, so order is kept
            out_valid <= spare_valid | in_fire;
            spare_valid <= 1'b0;
            in_ready <= 1'b1;
        end else if (in_fire) begin
            // Downstream stalled while a beat was accepted, park it in the spare
            spare_valid <= 1'b1;
            in_ready <= 1'b0;
        end
    end

    // The spare captures a beat only while the main register is held
    always_ff @(posedge clock) begin
        if (main_free) begin
            if (spare_valid) begin
                out_data <= spare_data;
            end else if (in_fire) begin
                out_data <= in_data;
            end
        end
        if (!main_free && in_fire) begin
            spare_data <= in_data;
        end
    end

endmodule

`default_nettype wire

// File: source/calib_regs.sv
// Calibration register block
// Holds the per-channel offsets and shifts and the global shift enable,
// written through a plain write strobe with no read-back

`timescale 1ns/100ps
`default_nettype none

`include "calib_config.svh"

module calib_regs (
    input logic clock,
    input logic reset,
    input logic reg_write,
    input logic [`CALIB_ADDR_WIDTH-1:0] reg_address,
    input logic [`CALIB_DATA_WIDTH-1:0] reg_data,
    output calib_pkg::calib_coeff_array_t coeffs,
    output logic shift_enable
);

    import calib_pkg::*;

    localparam int ADDR_WIDTH = `CALIB_ADDR_WIDTH;

    // Each channel owns an offset word at an even address and a shift word
    // at the odd address just above it
    always_ff @(posedge clock) begin
        if (!reset) begin
            coeffs <= '0;
            shift_enable <= 1'b0;
        end else if (reg_write) begin
            for (int c = 0; c < `CALIB_CHANNELS; c++) begin
                if (reg_address == ADDR_WIDTH'(REG_CHANNEL_STRIDE * c + REG_OFFSET_FIELD)) begin
                    coeffs[c].offset <= reg_data;
                end
                // Only the low bits of a shift write are meaningful
                if (reg_address == ADDR_WIDTH'(REG_CHANNEL_STRIDE * c + REG_SHIFT_FIELD)) begin
                    coeffs[c].shift <= reg_data[`CALIB_SHIFT_WIDTH-1:0];
                end
            end
            // The control word sits right after the last channel
            if (reg_address == ADDR_WIDTH'(REG_CONTROL_ADDRESS)) begin
                shift_enable <= reg_data[REG_SHIFT_ENABLE_BIT];
            end
            // Any other address falls through and leaves the state alone
        end
    end

endmodule

`default_nettype wire

// File: source/calib_pkg.sv
// Calibration package
// Stream payload types, per-channel coefficient types and the register map

`default_nettype none

`include "calib_config.svh"

package calib_pkg;

    // A single channel still needs one bit of channel field
    localparam int CHANNEL_WIDTH = (`CALIB_CHANNELS > 1) ? $clog2(`CALIB_CHANNELS) : 1;

    // The register map has two words per channel followed by the control word
    localparam int REG_CHANNEL_STRIDE = 2;
    localparam int REG_OFFSET_FIELD = 0;
    localparam int REG_SHIFT_FIELD = 1;
    localparam int REG_CONTROL_ADDRESS = REG_CHANNEL_STRIDE * `CALIB_CHANNELS;
    localparam int REG_SHIFT_ENABLE_BIT = 0;

    // Sample as it arrives from the acquisition side
    typedef struct packed {
        logic signed [`CALIB_DATA_WIDTH-1:0] data;
        logic [CHANNEL_WIDTH-1:0] channel;
    } raw_sample_t;

    // Sample after calibration with a flag that marks where a clamp acted
    typedef struct packed {
        logic signed [`CALIB_DATA_WIDTH-1:0] data;
        logic [CHANNEL_WIDTH-1:0] channel;
        logic saturated;
    } calibrated_sample_t;

    // Coefficients of one channel
    typedef struct packed {
        logic signed [`CALIB_DATA_WIDTH-1:0] offset;
        logic [`CALIB_SHIFT_WIDTH-1:0] shift;
    } calib_coeff_t;

    typedef calib_coeff_t [`CALIB_CHANNELS-1:0] calib_coeff_array_t;

endpackage

`default_nettype wire

// File: source/calib_config.svh
// Calibration front end configuration
// Sizes shared by the package, the register block and the datapath

`ifndef CALIB_CONFIG_SVH
`define CALIB_CONFIG_SVH

// Width of a signed sample and of a register data word
`define CALIB_DATA_WIDTH 16

// Number of acquisition channels carried on the stream
`define CALIB_CHANNELS 4

// Width of a per-channel shift amount, so shifts run from 0 to 15
`define CALIB_SHIFT_WIDTH 4

// Register address width, wide enough for two words per channel plus control
`define CALIB_ADDR_WIDTH 4

`endif
